// File: list.f
pipe_trace_pkg.sv
perf_counters.sv
hazard_ctrl.sv
pipe_tracker.sv
trace_fifo.sv
pipe_trace_top.sv
tb_clock_gen.sv
tb_pipe_trace.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the pipeline trace testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_pipe_trace -o sim_tb
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tb_pipe_trace.sv
`timescale 1ns/1ps

module tb_pipe_trace
    import pipe_trace_pkg::*;
();

    localparam int PAUSE_START = 100;
    localparam int PAUSE_LEN   = 40;

    logic               clk, rst;
    logic               instr_valid, instr_taken, instr_ready, trace_rd;
    op_t                instr_op, trace_op;
    logic [REG_W-1:0]   instr_rd, instr_rs1;
    logic               trace_valid, trace_flushed;
    logic [TAG_W-1:0]   trace_tag;
    logic [STAMP_W-1:0] trace_fetch, trace_exec, trace_wb, cycles;
    logic [STALL_W-1:0] trace_stalls;
    logic [CNT_W-1:0]   retired, stall_cycles, flushes, drops;

    // Op, fetch, exec, wb, stalls, flushed.
    logic [OP_W+3*STAMP_W+STALL_W:0] exp_rec [0:255];
    bit known [0:255];
    bit popped [0:255];
    int mismatches, failures, popped_cnt, issued;
    int model_retired, model_stalls, model_flushes;
    int last_retired = -1;
    int seed;
    logic [STAMP_W-1:0] now_cycle;
    logic [TAG_W-1:0]   next_tag;
    logic               md_valid, md_taken, me_valid, me_taken;
    op_t                md_op, me_op;
    logic [REG_W-1:0]   md_rs1, md_rd, me_rd;
    logic [TAG_W-1:0]   md_tag, me_tag;
    logic [STAMP_W-1:0] md_fetch, me_fetch;
    logic [STALL_W-1:0] md_stalls, me_stalls;

    tb_clock_gen clkgen0 (.clk(clk), .rst(rst));

    pipe_trace_top dut0 (.*);

    task automatic expect_rec(input logic [TAG_W-1:0] tag, input op_t op,
                              input logic [STAMP_W-1:0] f, input logic [STAMP_W-1:0] e,
                              input logic [STAMP_W-1:0] w, input logic [STALL_W-1:0] s,
                              input logic fl);
        exp_rec[tag] = {op, f, e, w, s, fl};
        known[tag] = 1'b1;
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            mismatches++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp_v, act_v);
        end
    endtask

    // Reference pipeline: decode and execute stages only.
    always @(posedge clk) begin : model
        logic m_flush, m_stall, m_accept;
        if (rst) begin
            now_cycle = '0;
            next_tag  = '0;
            md_valid  = 1'b0;
            me_valid  = 1'b0;
        end else begin
            m_flush  = me_valid && me_op == OP_BRANCH && me_taken;
            m_stall  = !m_flush && me_valid && me_op == OP_LOAD && me_rd != '0 &&
                       md_valid && md_rs1 == me_rd;
            m_accept = instr_valid && !m_stall;
            check_count("cycles", now_cycle, cycles);
            check_count("instr_ready", !m_stall, instr_ready);
            if (me_valid) begin
                expect_rec(me_tag, me_op, me_fetch, now_cycle, now_cycle + 2'd2, me_stalls, 0);
                model_retired++;
            end
            if (m_flush) begin
                model_flushes++;
                if (md_valid)
                    expect_rec(md_tag, md_op, md_fetch, '0, '0, md_stalls, 1'b1);
                if (m_accept)
                    expect_rec(next_tag, instr_op, now_cycle, '0, '0, '0, 1'b1);
            end
            model_stalls += m_stall;
            issued       += m_accept;
            me_valid  = md_valid && !m_stall && !m_flush; // Bubble on hold or kill.
            me_tag    = md_tag;
            me_op     = md_op;
            me_rd     = md_rd;
            me_taken  = md_taken;
            me_fetch  = md_fetch;
            me_stalls = md_stalls;
            if (m_flush) begin
                md_valid = 1'b0;
            end else if (m_stall) begin
                md_stalls = md_stalls + 1'b1;
            end else begin
                md_valid  = m_accept;
                md_tag    = next_tag;
                md_op     = instr_op;
                md_rd     = instr_rd;
                md_rs1    = instr_rs1;
                md_taken  = instr_taken;
                md_fetch  = now_cycle;
                md_stalls = '0;
            end
            next_tag  = next_tag + m_accept;
            now_cycle = now_cycle + 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && trace_rd && trace_valid) begin
            if (!known[trace_tag] || popped[trace_tag]) begin
                failures++;
                $display("Record for tag %0d was never issued or came out twice", trace_tag);
            end else if (exp_rec[trace_tag] != {trace_op, trace_fetch, trace_exec, trace_wb,
                                                trace_stalls, trace_flushed}) begin
                mismatches++;
                $display("MISMATCH trace_record tag %0d expected %h actual %h", trace_tag,
                         exp_rec[trace_tag], {trace_op, trace_fetch, trace_exec, trace_wb,
                         trace_stalls, trace_flushed});
            end
            if (!trace_flushed) begin
                if (int'(trace_tag) <= last_retired) begin
                    failures++;
                    $display("Tag %0d retired after tag %0d, out of acceptance order",
                             trace_tag, last_retired);
                end
                last_retired = int'(trace_tag);
            end
            popped[trace_tag] = 1'b1;
            popped_cnt++;
        end
    end

    // Consumer pops every valid record outside the pause window.
    initial begin
        trace_rd = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            trace_rd = trace_valid &&
                       !(now_cycle >= PAUSE_START && now_cycle < PAUSE_START + PAUSE_LEN);
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(rst) |-> !trace_valid && instr_ready)
        else begin
            mismatches++;
            $display("MISMATCH reset_state expected valid 0 ready 1 actual valid %0d ready %0d",
                     $sampled(trace_valid), $sampled(instr_ready));
        end

    a_ready_one_cycle: assert property (
        @(posedge clk) disable iff (rst) !instr_ready |=> instr_ready
    ) else begin
        mismatches++;
        $display("MISMATCH ready_low_once expected 1 actual %0d", $sampled(instr_ready));
    end

    a_retired_stamps: assert property (
        @(posedge clk) disable iff (rst) trace_valid && !trace_flushed |->
            trace_exec == STAMP_W'(trace_fetch + 2 + trace_stalls) &&
            trace_wb == STAMP_W'(trace_exec + 2)
    ) else begin
        mismatches++;
        $display("MISMATCH retired_stamps expected exec %0d wb %0d actual exec %0d wb %0d",
                 STAMP_W'($sampled(trace_fetch) + 2 + $sampled(trace_stalls)),
                 STAMP_W'($sampled(trace_exec) + 2), $sampled(trace_exec), $sampled(trace_wb));
    end

    a_flushed_stamps: assert property (
        @(posedge clk) disable iff (rst) trace_valid && trace_flushed |->
            trace_exec == '0 && trace_wb == '0
    ) else begin
        mismatches++;
        $display("MISMATCH flushed_stamps expected exec 0 wb 0 actual exec %0d wb %0d",
                 $sampled(trace_exec), $sampled(trace_wb));
    end

    task automatic send_instr(input op_t op, input logic [REG_W-1:0] rd,
                              input logic [REG_W-1:0] rs1, input logic taken);
        int waited;
        instr_valid = 1'b1;
        instr_op    = op;
        instr_rd    = rd;
        instr_rs1   = rs1;
        instr_taken = taken;
        waited      = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!instr_ready && waited < 10);
        if (!instr_ready) begin
            failures++;
            $display("Instruction was not accepted within 10 cycles");
        end
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        instr_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    initial begin
        int waited;
        int idle_run;
        logic [31:0] r;
        instr_valid = 1'b0;
        instr_op    = OP_NOP;
        instr_rd    = '0;
        instr_rs1   = '0;
        instr_taken = 1'b0;
        seed        = 32'hb870;
        waited      = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (rst && waited < 40);
        if (rst) begin
            failures++;
            $display("Reset was never released");
        end
        #1;
        send_instr(OP_ALU, 5'd1, 5'd0, 1'b0);
        send_instr(OP_ALU, 5'd2, 5'd1, 1'b0);
        send_instr(OP_LOAD, 5'd3, 5'd2, 1'b0);
        send_instr(OP_ALU, 5'd4, 5'd3, 1'b0); // Load-use on r3.
        send_instr(OP_LOAD, 5'd0, 5'd1, 1'b0);
        send_instr(OP_ALU, 5'd5, 5'd0, 1'b0); // Load to r0, no hold.
        send_instr(OP_BRANCH, 5'd0, 5'd4, 1'b1);
        send_instr(OP_ALU, 5'd6, 5'd5, 1'b0); // Killed by the branch.
        send_instr(OP_ALU, 5'd7, 5'd6, 1'b0); // Killed by the branch.
        send_instr(OP_BRANCH, 5'd0, 5'd1, 1'b0);
        send_instr(OP_NOP, 5'd0, 5'd0, 1'b0);
        idle_cycles(6);
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            send_instr(op_t'(r[1:0]), {3'b000, r[3:2]}, {3'b000, r[5:4]}, r[8:6] == 3'd0);
            if (r[12:9] == 4'd0)
                idle_cycles(1);
        end
        idle_run = 0;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (trace_valid)
                idle_run = 0;
            else
                idle_run++;
        end while (idle_run < 8 && waited < 100);
        if (idle_run < 8) begin
            failures++;
            $display("Trace did not drain within 100 cycles");
        end
        repeat (10) @(posedge clk);
        check_count("trace_valid_idle", 0, trace_valid);
        check_count("retired", model_retired, retired);
        check_count("stall_cycles", model_stalls, stall_cycles);
        check_count("flushes", 2 * model_flushes, flushes);
        check_count("drops", issued - popped_cnt, drops);
        if (drops == '0) begin
            failures++;
            $display("No record was dropped during the read pause");
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: pipe_trace_top.sv
`timescale 1ns/1ps

module pipe_trace_top
    import pipe_trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  op_t                instr_op,
    input  logic [REG_W-1:0]   instr_rd,
    input  logic [REG_W-1:0]   instr_rs1,
    input  logic               instr_taken,
    output logic               instr_ready,
    output logic               trace_valid,
    output logic [TAG_W-1:0]   trace_tag,
    output op_t                trace_op,
    output logic [STAMP_W-1:0] trace_fetch,
    output logic [STAMP_W-1:0] trace_exec,
    output logic [STAMP_W-1:0] trace_wb,
    output logic [STALL_W-1:0] trace_stalls,
    output logic               trace_flushed,
    input  logic               trace_rd,
    output logic [STAMP_W-1:0] cycles,
    output logic [CNT_W-1:0]   retired,
    output logic [CNT_W-1:0]   stall_cycles,
    output logic [CNT_W-1:0]   flushes,
    output logic [CNT_W-1:0]   drops
);

    logic               stall, flush, retire, drop;
    logic               dec_valid, ex_valid, ex_taken;
    logic [REG_W-1:0]   dec_rs1, ex_rd;
    op_t                ex_op;
    logic               rec_wr;
    logic [TRACE_W-1:0] rec_data;
    logic [TRACE_W-1:0] rd_data;
    logic [OP_W-1:0]    trace_op_bits;

    assign {trace_tag, trace_op_bits, trace_fetch, trace_exec, trace_wb,
            trace_stalls, trace_flushed} = rd_data;
    assign trace_op = op_t'(trace_op_bits);

    perf_counters u_perf (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .retire(retire),
        .drop(drop), .cycles(cycles), .retired(retired),
        .stall_cycles(stall_cycles), .flushes(flushes), .drops(drops)
    );

    hazard_ctrl u_hazard (
        .clk(clk), .rst(rst), .dec_valid(dec_valid), .dec_rs1(dec_rs1),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd), .ex_taken(ex_taken),
        .stall(stall), .flush(flush)
    );

    pipe_tracker u_tracker (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_op(instr_op),
        .instr_rd(instr_rd), .instr_rs1(instr_rs1), .instr_taken(instr_taken),
        .stall(stall), .flush(flush), .cycles(cycles), .instr_ready(instr_ready),
        .dec_valid(dec_valid), .dec_rs1(dec_rs1), .ex_valid(ex_valid),
        .ex_op(ex_op), .ex_rd(ex_rd), .ex_taken(ex_taken), .rec_wr(rec_wr),
        .rec_data(rec_data), .retire(retire)
    );

    trace_fifo u_fifo (
        .clk(clk), .rst(rst), .wr(rec_wr), .wr_data(rec_data), .rd(trace_rd),
        .valid(trace_valid), .rd_data(rd_data), .drop(drop)
    );

endmodule

// File: trace_fifo.sv
`timescale 1ns/1ps

module trace_fifo
    import pipe_trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               wr,
    input  logic [TRACE_W-1:0] wr_data,
    input  logic               rd,
    output logic               valid,
    output logic [TRACE_W-1:0] rd_data,
    output logic               drop
);

    logic [TRACE_W-1:0] mem [0:FIFO_DEPTH-1];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full  = (count == FIFO_DEPTH[FIFO_AW:0]);
    assign valid = (count != '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && valid; // Pop ignored when empty.
    assign drop  = wr && full;

    assign rd_data = mem[rd_ptr]; // Head shows ahead.

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_occupancy: assert property (
        @(posedge clk) disable iff (rst)
        count <= FIFO_DEPTH
    ) else $error("trace FIFO overfilled");

endmodule

// File: pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker
    import pipe_trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  op_t                instr_op,
    input  logic [REG_W-1:0]   instr_rd,
    input  logic [REG_W-1:0]   instr_rs1,
    input  logic               instr_taken,
    input  logic               stall,
    input  logic               flush,
    input  logic [STAMP_W-1:0] cycles,
    output logic               instr_ready,
    output logic               dec_valid,
    output logic [REG_W-1:0]   dec_rs1,
    output logic               ex_valid,
    output op_t                ex_op,
    output logic [REG_W-1:0]   ex_rd,
    output logic               ex_taken,
    output logic               rec_wr,
    output logic [TRACE_W-1:0] rec_data,
    output logic               retire
);

    logic accept;
    logic [TAG_W-1:0] next_tag;

    logic d_valid, e_valid, m_valid, w_valid;
    logic [TAG_W-1:0] d_tag, e_tag, m_tag, w_tag;
    op_t d_op, e_op, m_op, w_op;
    logic [REG_W-1:0] d_rd, d_rs1, e_rd;
    logic d_taken, e_taken;
    logic [STAMP_W-1:0] d_fetch, e_fetch, m_fetch, w_fetch;
    logic [STAMP_W-1:0] m_exec, w_exec;
    logic [STALL_W-1:0] d_stalls, e_stalls, m_stalls, w_stalls;

    logic [TRACE_W-1:0] pend [0:PEND_DEPTH-1];
    logic [TRACE_W-1:0] pend_next [0:PEND_DEPTH-1];
    logic [PEND_CW-1:0] pend_cnt;
    logic [PEND_CW-1:0] pend_cnt_next;
    logic [TRACE_W-1:0] q [0:PEND_DEPTH+2];
    logic [PEND_CW:0]   n;

    function automatic logic [TRACE_W-1:0] pack_rec(
        input logic [TAG_W-1:0]   tag,
        input op_t                op,
        input logic [STAMP_W-1:0] fetch_t,
        input logic [STAMP_W-1:0] exec_t,
        input logic [STAMP_W-1:0] wb_t,
        input logic [STALL_W-1:0] stalls,
        input logic               flushed
    );
        return {tag, op, fetch_t, exec_t, wb_t, stalls, flushed};
    endfunction

    assign instr_ready = !stall;
    assign accept      = instr_valid && instr_ready;
    assign retire      = w_valid;

    assign dec_valid = d_valid;
    assign dec_rs1   = d_rs1;
    assign ex_valid  = e_valid;
    assign ex_op     = e_op;
    assign ex_rd     = e_rd;
    assign ex_taken  = e_taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next_tag <= '0;
            d_valid  <= 1'b0;
            e_valid  <= 1'b0;
            m_valid  <= 1'b0;
            w_valid  <= 1'b0;
            pend_cnt <= '0;
        end else begin
            if (accept)
                next_tag <= next_tag + 1'b1;
            if (flush)
                d_valid <= 1'b0;
            else if (!stall)
                d_valid <= accept;
            e_valid  <= d_valid && !stall && !flush; // Bubble on hold or kill.
            m_valid  <= e_valid;
            w_valid  <= m_valid;
            pend_cnt <= pend_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            d_stalls <= d_stalls + 1'b1;
        end else begin
            d_tag    <= next_tag;
            d_op     <= instr_op;
            d_rd     <= instr_rd;
            d_rs1    <= instr_rs1;
            d_taken  <= instr_taken;
            d_fetch  <= cycles; // Fetch stamp is the accept cycle.
            d_stalls <= '0;
        end
        e_tag    <= d_tag;
        e_op     <= d_op;
        e_rd     <= d_rd;
        e_taken  <= d_taken;
        e_fetch  <= d_fetch;
        e_stalls <= d_stalls;
        m_tag    <= e_tag;
        m_op     <= e_op;
        m_fetch  <= e_fetch;
        m_exec   <= cycles; // Cycle spent in execute.
        m_stalls <= e_stalls;
        w_tag    <= m_tag;
        w_op     <= m_op;
        w_fetch  <= m_fetch;
        w_exec   <= m_exec;
        w_stalls <= m_stalls;
        for (int i = 0; i < PEND_DEPTH; i++) begin
            pend[i] <= pend_next[i];
        end
    end

    // Queue new records behind pending ones, oldest written first.
    always_comb begin
        q = '{default: '0};
        for (int i = 0; i < PEND_DEPTH; i++) begin
            q[i] = pend[i];
        end
        n = {1'b0, pend_cnt};
        if (w_valid) begin
            q[n] = pack_rec(w_tag, w_op, w_fetch, w_exec, cycles, w_stalls, 1'b0);
            n = n + 1'b1;
        end
        if (flush && d_valid) begin
            q[n] = pack_rec(d_tag, d_op, d_fetch, '0, '0, d_stalls, 1'b1);
            n = n + 1'b1;
        end
        if (flush && accept) begin
            q[n] = pack_rec(next_tag, instr_op, cycles, '0, '0, '0, 1'b1);
            n = n + 1'b1;
        end
        rec_wr   = (n != '0);
        rec_data = q[0];
        for (int i = 0; i < PEND_DEPTH; i++) begin
            pend_next[i] = q[i+1];
        end
        pend_cnt_next = rec_wr ? PEND_CW'(n - 1'b1) : '0;
    end

endmodule

// File: hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl
    import pipe_trace_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             dec_valid,
    input  logic [REG_W-1:0] dec_rs1,
    input  logic             ex_valid,
    input  op_t              ex_op,
    input  logic [REG_W-1:0] ex_rd,
    input  logic             ex_taken,
    output logic             stall,
    output logic             flush
);

    haz_state_t state;
    haz_state_t state_next;
    logic       load_use;
    logic       branch_taken;

    // Load in execute feeding the instruction in decode.
    assign load_use = dec_valid && ex_valid && (ex_op == OP_LOAD) &&
                      (ex_rd != '0) && (dec_rs1 == ex_rd);

    assign branch_taken = ex_valid && (ex_op == OP_BRANCH) && ex_taken;

    // Flush wins over stall.
    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

    always_comb begin
        if (flush)
            state_next = HZ_FLUSH;
        else if (stall)
            state_next = HZ_STALL;
        else
            state_next = HZ_RUN;
    end

    // Remembers why the previous cycle held.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= HZ_RUN;
        end else begin
            state <= state_next;
        end
    end

    a_no_stall_flush: assert property (
        @(posedge clk) disable iff (rst)
        !(stall && flush)
    ) else $error("stall and flush together");

    // The bubble sent to execute must clear the load-use match.
    a_stall_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        stall |-> state != HZ_STALL
    ) else $error("stall held for two cycles");

endmodule

// File: perf_counters.sv
`timescale 1ns/1ps

module perf_counters
    import pipe_trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  logic               retire,
    input  logic               drop,
    output logic [STAMP_W-1:0] cycles,
    output logic [CNT_W-1:0]   retired,
    output logic [CNT_W-1:0]   stall_cycles,
    output logic [CNT_W-1:0]   flushes,
    output logic [CNT_W-1:0]   drops
);

    function automatic logic [CNT_W-1:0] sat_add(
        input logic [CNT_W-1:0] value,
        input logic [1:0]       step
    );
        logic [CNT_W:0] sum;
        sum = {1'b0, value} + step;
        return sum[CNT_W] ? {CNT_W{1'b1}} : sum[CNT_W-1:0];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 1'b1; // Free running, wraps.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retired      <= '0;
            stall_cycles <= '0;
            flushes      <= '0;
            drops        <= '0;
        end else begin
            if (retire)
                retired <= sat_add(retired, 2'd1);
            if (stall)
                stall_cycles <= sat_add(stall_cycles, 2'd1);
            if (flush)
                flushes <= sat_add(flushes, 2'd2); // Fetch and decode both killed.
            if (drop)
                drops <= sat_add(drops, 2'd1);
        end
    end

    a_cycles_step: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> cycles == $past(cycles) + 1'b1
    ) else $error("cycle counter skipped");

endmodule

// File: pipe_trace_pkg.sv
package pipe_trace_pkg;

    // Cycle counter and every stamp.
    localparam int STAMP_W = 16;

    // Instruction tag, wraps mod 256.
    localparam int TAG_W = 8;

    localparam int REG_W = 5;
    localparam int STALL_W = 4;
    localparam int OP_W = 2;

    // Saturating event counters.
    localparam int CNT_W = 16;

    // Tag, op, fetch, exec and wb stamps, stall count, flushed flag.
    localparam int TRACE_W = TAG_W + OP_W + 3 * STAMP_W + STALL_W + 1;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // Retire plus two flushed records can land in one cycle.
    localparam int PEND_DEPTH = 3;
    localparam int PEND_CW = $clog2(PEND_DEPTH + 1);

    typedef enum logic [OP_W-1:0] {
        OP_NOP    = 2'd0,
        OP_ALU    = 2'd1,
        OP_LOAD   = 2'd2,
        OP_BRANCH = 2'd3
    } op_t;

    typedef enum logic [1:0] {
        HZ_RUN   = 2'd0,
        HZ_STALL = 2'd1,
        HZ_FLUSH = 2'd2
    } haz_state_t;

endpackage
